// File: rtl/lpif_link_pkg.sv
// LPIF link slave package
`default_nettype none

package lpif_link_pkg;

  ////////////////////////////////////////////////////////////
  // LPIF field widths

  localparam int state_w     = 4;
  localparam int protid_w    = 2;
  localparam int data_w      = 64;
  localparam int dvalid_w    = 1;
  localparam int crc_w       = 2;
  localparam int crc_valid_w = 1;
  localparam int valid_w     = 1;

  ////////////////////////////////////////////////////////////
  // Link word layout, valid at bit 0, state at the top

  localparam int valid_lsb     = 0;
  localparam int crc_valid_lsb = valid_lsb + valid_w;
  localparam int crc_lsb       = crc_valid_lsb + crc_valid_w;
  localparam int dvalid_lsb    = crc_lsb + crc_w;
  localparam int data_lsb      = dvalid_lsb + dvalid_w;
  localparam int protid_lsb    = data_lsb + data_w;
  localparam int state_lsb     = protid_lsb + protid_w;
  localparam int lpif_word_w   = state_lsb + state_w;

  // Word bits per lane, lane 0 takes the low part
  localparam int lane_data0_w = 38;
  localparam int lane_data1_w = lpif_word_w - lane_data0_w;

  // Auto-sync walk from offline to fully online
  typedef enum logic [2:0] {
    sync_idle,
    sync_tx_wait,
    sync_tx_up,
    sync_rx_wait,
    sync_rx_settle,
    sync_up
  } sync_state_t;

endpackage

`default_nettype wire

// File: rtl/lpif_word_if.sv
// LPIF link word bus
`timescale 1ns/100ps
`default_nettype none

interface lpif_word_if import lpif_link_pkg::*; ();

  // Packed word from the upstream fields
  logic [lpif_word_w-1:0] tx_word;

  // Rebuilt word from the lanes, one strobe per word
  logic [lpif_word_w-1:0] rx_word;
  logic                   rx_push;

  // Delayed online levels from auto-sync
  logic                   tx_online_delay;
  logic                   rx_online_delay;

  // Word mapper side
  modport map (
    output tx_word,
    input  rx_word,
    input  rx_push,
    input  tx_online_delay,
    input  rx_online_delay
  );

  // Lane concatenator side
  modport phy (
    input  tx_word,
    output rx_word,
    output rx_push,
    input  tx_online_delay,
    input  rx_online_delay
  );

endinterface

`default_nettype wire

// File: rtl/link_sync_cfg.sv
// Auto-sync delay configuration
`timescale 1ns/100ps
`default_nettype none

module link_sync_cfg #(
  parameter int delay_w = 16
) (
  input  logic               clk_wr,
  input  logic               rst_n,

  // Session level, high freezes the shadow copy
  input  logic               tx_online,

  // Host side values
  input  logic [delay_w-1:0] delay_x_value,
  input  logic [delay_w-1:0] delay_y_value,
  input  logic [delay_w-1:0] delay_z_value,

  // Shadow copy seen by the counters
  output logic [delay_w-1:0] delay_x,
  output logic [delay_w-1:0] delay_y,
  output logic [delay_w-1:0] delay_z
);

  ////////////////////////////////////////////////////////////
  // Shadow registers

  // Track host values while offline
  // Hold last capture for the whole online session
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      delay_x <= '0;
      delay_y <= '0;
      delay_z <= '0;
    end else if (!tx_online) begin
      delay_x <= delay_x_value;
      delay_y <= delay_y_value;
      delay_z <= delay_z_value;
    end
  end

endmodule

`default_nettype wire

// File: rtl/link_auto_sync.sv
// Link online auto-sync
`timescale 1ns/100ps
`default_nettype none

module link_auto_sync import lpif_link_pkg::*; #(
  parameter int delay_w = 16
) (
  input  logic               clk_wr,
  input  logic               rst_n,

  // Raw online levels
  input  logic               tx_online,
  input  logic               rx_online,

  // Frozen delay counts
  input  logic [delay_w-1:0] delay_x,
  input  logic [delay_w-1:0] delay_y,
  input  logic [delay_w-1:0] delay_z,

  // Delayed levels and lane strobe
  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               tx_stb_bit,

  output logic [31:0]        debug_status
);

  sync_state_t        state_q;
  sync_state_t        state_nxt;
  logic [delay_w-1:0] cnt_q;
  logic [delay_w-1:0] cnt_nxt;
  logic               tx_up_nxt;
  logic               rx_up_nxt;

  ////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_nxt = state_q;
    cnt_nxt   = cnt_q;
    case (state_q)
      sync_idle: begin
        if (tx_online) begin
          state_nxt = sync_tx_wait;
          cnt_nxt   = delay_x;
        end
      end
      sync_tx_wait: begin
        if (!tx_online) state_nxt = sync_idle;
        else if (cnt_q == '0) state_nxt = sync_tx_up;
        else cnt_nxt = cnt_q - 1'b1;
      end
      // Wait here until the far side reports rx online
      sync_tx_up: begin
        if (!tx_online) begin
          state_nxt = sync_idle;
        end else if (rx_online) begin
          state_nxt = sync_rx_wait;
          cnt_nxt   = delay_y;
        end
      end
      sync_rx_wait: begin
        if (!tx_online) begin
          state_nxt = sync_idle;
        end else if (!rx_online) begin
          state_nxt = sync_tx_up;
        end else if (cnt_q == '0) begin
          state_nxt = sync_rx_settle;
          cnt_nxt   = delay_z;
        end else begin
          cnt_nxt = cnt_q - 1'b1;
        end
      end
      sync_rx_settle: begin
        if (!tx_online) state_nxt = sync_idle;
        else if (!rx_online) state_nxt = sync_tx_up;
        else if (cnt_q == '0) state_nxt = sync_up;
        else cnt_nxt = cnt_q - 1'b1;
      end
      sync_up: begin
        if (!tx_online) state_nxt = sync_idle;
        else if (!rx_online) state_nxt = sync_tx_up;
      end
      default: state_nxt = sync_idle;
    endcase
  end

  // Levels decoded from the next state, so outputs and status line up
  assign tx_up_nxt = (state_nxt inside {sync_tx_up, sync_rx_wait, sync_rx_settle, sync_up});
  assign rx_up_nxt = (state_nxt == sync_up);

  ////////////////////////////////////////////////////////////
  // State, levels and status registers

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      state_q         <= sync_idle;
      cnt_q           <= '0;
      tx_online_delay <= 1'b0;
      rx_online_delay <= 1'b0;
      debug_status    <= '0;
    end else begin
      state_q         <= state_nxt;
      cnt_q           <= cnt_nxt;
      tx_online_delay <= tx_up_nxt;
      rx_online_delay <= rx_up_nxt;
      // Bit 19 tx level, bit 18 rx level
      debug_status    <= {12'h000, tx_up_nxt, rx_up_nxt, 18'h00000};
    end
  end

  // Persistent strobe while tx is up
  assign tx_stb_bit = tx_online_delay;

  // Rx side never ahead of tx side
  rx_needs_tx_a : assert property (
    @(posedge clk_wr) disable iff (!rst_n) rx_online_delay |-> tx_online_delay
  ) else $error("rx_online_delay high without tx_online_delay");

endmodule

`default_nettype wire

// File: rtl/lpif_word_map.sv
// LPIF field to link word mapper
`timescale 1ns/100ps
`default_nettype none

module lpif_word_map import lpif_link_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  // Upstream fields
  input  logic [state_w-1:0]     ustrm_state,
  input  logic [protid_w-1:0]    ustrm_protid,
  input  logic [data_w-1:0]      ustrm_data,
  input  logic [dvalid_w-1:0]    ustrm_dvalid,
  input  logic [crc_w-1:0]       ustrm_crc,
  input  logic [crc_valid_w-1:0] ustrm_crc_valid,
  input  logic [valid_w-1:0]     ustrm_valid,

  // Downstream fields
  output logic [state_w-1:0]     dstrm_state,
  output logic [protid_w-1:0]    dstrm_protid,
  output logic [data_w-1:0]      dstrm_data,
  output logic [dvalid_w-1:0]    dstrm_dvalid,
  output logic [crc_w-1:0]       dstrm_crc,
  output logic [crc_valid_w-1:0] dstrm_crc_valid,
  output logic [valid_w-1:0]     dstrm_valid,

  lpif_word_if.map               word_bus
);

  ////////////////////////////////////////////////////////////
  // Transmit packing

  // MSB first, state on top, valid at bit 0
  assign word_bus.tx_word = {ustrm_state,
                             ustrm_protid,
                             ustrm_data,
                             ustrm_dvalid,
                             ustrm_crc,
                             ustrm_crc_valid,
                             ustrm_valid};

  ////////////////////////////////////////////////////////////
  // Receive unpacking

  // Output register of the rx path
  // Zero whenever no word arrives this cycle
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_data      <= '0;
      dstrm_dvalid    <= '0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= '0;
      dstrm_valid     <= '0;
    end else if (word_bus.rx_push && word_bus.rx_online_delay) begin
      dstrm_state     <= word_bus.rx_word[state_lsb +: state_w];
      dstrm_protid    <= word_bus.rx_word[protid_lsb +: protid_w];
      dstrm_data      <= word_bus.rx_word[data_lsb +: data_w];
      dstrm_dvalid    <= word_bus.rx_word[dvalid_lsb +: dvalid_w];
      dstrm_crc       <= word_bus.rx_word[crc_lsb +: crc_w];
      dstrm_crc_valid <= word_bus.rx_word[crc_valid_lsb +: crc_valid_w];
      dstrm_valid     <= word_bus.rx_word[valid_lsb +: valid_w];
    end else begin
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_data      <= '0;
      dstrm_dvalid    <= '0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= '0;
      dstrm_valid     <= '0;
    end
  end

  // Delivered word must come from an online rx session
  dstrm_valid_online_a : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
      dstrm_valid[0] |-> $past(word_bus.rx_online_delay)
  ) else $error("dstrm_valid without rx_online_delay");

endmodule

`default_nettype wire

// File: rtl/phy_lane_concat.sv
// Two-lane PHY concatenator
`timescale 1ns/100ps
`default_nettype none

module phy_lane_concat import lpif_link_pkg::*; #(
  parameter int lane_w = 40
) (
  input  logic              clk_wr,
  input  logic              rst_n,

  // Lane strobe from auto-sync
  input  logic              tx_stb_bit,

  // PHY lanes
  output logic [lane_w-1:0] tx_phy0,
  output logic [lane_w-1:0] tx_phy1,
  input  logic [lane_w-1:0] rx_phy0,
  input  logic [lane_w-1:0] rx_phy1,

  lpif_word_if.phy          word_bus
);

  // Lane 0 control bits sit above its data
  localparam int stb_idx = lane_data0_w;
  localparam int mrk_idx = lane_w - 1;

  logic [lane_w-1:0]       tx_lane0_nxt;
  logic [lane_w-1:0]       tx_lane1_nxt;
  logic [lane_data0_w-1:0] rx_data0_q;
  logic [lane_data1_w-1:0] rx_data1_q;
  logic                    rx_stb_q;

  ////////////////////////////////////////////////////////////
  // Transmit split

  always_comb begin
    tx_lane0_nxt = '0;
    tx_lane1_nxt = '0;
    // Low word bits on lane 0
    tx_lane0_nxt[lane_data0_w-1:0] = word_bus.tx_word[lane_data0_w-1:0];
    tx_lane0_nxt[stb_idx]          = tx_stb_bit;
    // No user marker on this link
    tx_lane0_nxt[mrk_idx]          = 1'b0;
    // High word bits on lane 1, spare bits and marker stay zero
    tx_lane1_nxt[lane_data1_w-1:0] = word_bus.tx_word[lpif_word_w-1:lane_data0_w];
  end

  // Lanes idle at zero while tx is not up
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (word_bus.tx_online_delay) begin
      tx_phy0 <= tx_lane0_nxt;
      tx_phy1 <= tx_lane1_nxt;
    end else begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive rebuild

  // Lane register, first stage of the rx path
  always_ff @(posedge clk_wr) begin
    rx_data0_q <= rx_phy0[lane_data0_w-1:0];
    rx_data1_q <= rx_phy1[lane_data1_w-1:0];
    rx_stb_q   <= rx_phy0[stb_idx];
  end

  assign word_bus.rx_word = {rx_data1_q, rx_data0_q};

  // Push only a strobed word during an rx session
  assign word_bus.rx_push = rx_stb_q & word_bus.rx_online_delay;

  // Offline cycle leaves quiet lanes behind it
  tx_lanes_quiet_a : assert property (
    @(posedge clk_wr) disable iff (!rst_n)
      !word_bus.tx_online_delay |=> (tx_phy0 == '0 && tx_phy1 == '0)
  ) else $error("tx lanes active after tx_online_delay low");

endmodule

`default_nettype wire

// File: rtl/lpif_link_slave_top.sv
// LPIF two-lane link slave
`timescale 1ns/100ps
`default_nettype none

module lpif_link_slave_top import lpif_link_pkg::*; #(
  parameter int lane_w  = 40,
  parameter int delay_w = 16
) (
  // Clocking and control
  input  logic                   clk_wr,
  input  logic                   rst_n,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [delay_w-1:0]     delay_x_value,
  input  logic [delay_w-1:0]     delay_y_value,
  input  logic [delay_w-1:0]     delay_z_value,

  // PHY lanes
  output logic [lane_w-1:0]      tx_phy0,
  input  logic [lane_w-1:0]      rx_phy0,
  output logic [lane_w-1:0]      tx_phy1,
  input  logic [lane_w-1:0]      rx_phy1,

  // Downstream
  output logic [state_w-1:0]     dstrm_state,
  output logic [protid_w-1:0]    dstrm_protid,
  output logic [data_w-1:0]      dstrm_data,
  output logic [dvalid_w-1:0]    dstrm_dvalid,
  output logic [crc_w-1:0]       dstrm_crc,
  output logic [crc_valid_w-1:0] dstrm_crc_valid,
  output logic [valid_w-1:0]     dstrm_valid,

  // Upstream
  input  logic [state_w-1:0]     ustrm_state,
  input  logic [protid_w-1:0]    ustrm_protid,
  input  logic [data_w-1:0]      ustrm_data,
  input  logic [dvalid_w-1:0]    ustrm_dvalid,
  input  logic [crc_w-1:0]       ustrm_crc,
  input  logic [crc_valid_w-1:0] ustrm_crc_valid,
  input  logic [valid_w-1:0]     ustrm_valid,

  // Debug
  output logic [31:0]            rx_downstream_debug_status,
  output logic [31:0]            tx_upstream_debug_status
);

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic [delay_w-1:0] delay_x;
  logic [delay_w-1:0] delay_y;
  logic [delay_w-1:0] delay_z;
  logic               tx_online_delay;
  logic               rx_online_delay;
  logic               tx_stb_bit;
  logic [31:0]        debug_status;

  lpif_word_if word_bus ();

  // Online levels shared by both word path ends
  assign word_bus.tx_online_delay = tx_online_delay;
  assign word_bus.rx_online_delay = rx_online_delay;

  // One status word feeds both debug views
  assign rx_downstream_debug_status = debug_status;
  assign tx_upstream_debug_status   = debug_status;

  ////////////////////////////////////////////////////////////
  // Auto-sync and its configuration

  link_sync_cfg #(
    .delay_w (delay_w)
  ) link_sync_cfg_inst (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .tx_online     (tx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .delay_x       (delay_x),
    .delay_y       (delay_y),
    .delay_z       (delay_z)
  );

  link_auto_sync #(
    .delay_w (delay_w)
  ) link_auto_sync_inst (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x         (delay_x),
    .delay_y         (delay_y),
    .delay_z         (delay_z),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .debug_status    (debug_status)
  );

  ////////////////////////////////////////////////////////////
  // Word path

  lpif_word_map lpif_word_map_inst (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .word_bus        (word_bus)
  );

  phy_lane_concat #(
    .lane_w (lane_w)
  ) phy_lane_concat_inst (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .tx_stb_bit (tx_stb_bit),
    .tx_phy0    (tx_phy0),
    .tx_phy1    (tx_phy1),
    .rx_phy0    (rx_phy0),
    .rx_phy1    (rx_phy1),
    .word_bus   (word_bus)
  );

endmodule

`default_nettype wire

// File: testbench/tb_lpif_link_slave.sv
// LPIF link slave testbench
`timescale 1ns/100ps
`default_nettype none

module tb_lpif_link_slave import lpif_link_pkg::*; ();

  localparam int lane_w          = 40;
  localparam int delay_w         = 16;
  localparam int clk_period      = 40;
  localparam int num_sessions    = 10;
  localparam int traffic_cycles  = 40;
  localparam int rise_limit      = 64;
  // Worst case per session, each rise wait running to its limit
  localparam int session_cycles  = 3 * rise_limit + traffic_cycles + 12;
  localparam int total_cycles    = 12 + num_sessions * session_cycles;
  localparam int watchdog_margin = 100;
  localparam logic [31:0] lcg_seed = 32'h9d01570b;

  ////////////////////////////////////////////////////////////
  // DUT signals

  logic                   clk_wr = 1'b0;
  logic                   rst_n;
  logic                   tx_online;
  logic                   rx_online;
  logic [delay_w-1:0]     delay_x_value;
  logic [delay_w-1:0]     delay_y_value;
  logic [delay_w-1:0]     delay_z_value;
  logic [lane_w-1:0]      tx_phy0;
  logic [lane_w-1:0]      rx_phy0;
  logic [lane_w-1:0]      tx_phy1;
  logic [lane_w-1:0]      rx_phy1;
  logic [state_w-1:0]     dstrm_state;
  logic [protid_w-1:0]    dstrm_protid;
  logic [data_w-1:0]      dstrm_data;
  logic [dvalid_w-1:0]    dstrm_dvalid;
  logic [crc_w-1:0]       dstrm_crc;
  logic [crc_valid_w-1:0] dstrm_crc_valid;
  logic [valid_w-1:0]     dstrm_valid;
  logic [state_w-1:0]     ustrm_state;
  logic [protid_w-1:0]    ustrm_protid;
  logic [data_w-1:0]      ustrm_data;
  logic [dvalid_w-1:0]    ustrm_dvalid;
  logic [crc_w-1:0]       ustrm_crc;
  logic [crc_valid_w-1:0] ustrm_crc_valid;
  logic [valid_w-1:0]     ustrm_valid;
  logic [31:0]            rx_downstream_debug_status;
  logic [31:0]            tx_upstream_debug_status;

  int          errors = 0;
  int          checks = 0;
  string       test_name = "startup";
  logic [31:0] main_rand;
  logic [31:0] traffic_rand;

  // Model state, as the DUT stands after the last rising edge
  logic [delay_w-1:0]     m_dx = '0;
  logic [delay_w-1:0]     m_dy = '0;
  logic [delay_w-1:0]     m_dz = '0;
  int                     m_tx_cnt = 0;
  int                     m_rx_cnt = 0;
  logic                   m_tx_dly = 1'b0;
  logic                   m_rx_dly = 1'b0;
  logic [lane_w-1:0]      m_phy0 = '0;
  logic [lane_w-1:0]      m_phy1 = '0;
  logic [lpif_word_w-1:0] m_rx_word = '0;
  logic                   m_rx_stb = 1'b0;
  logic [lpif_word_w-1:0] m_dstrm = '0;

  lpif_link_slave_top #(
    .lane_w  (lane_w),
    .delay_w (delay_w)
  ) lpif_link_slave_top_inst (.*);

  initial begin
    forever #(clk_period / 2) clk_wr = ~clk_wr;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string what, input logic [127:0] exp_val,
                                 input logic [127:0] act_val);
    errors++;
    $display("ERROR %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
  endtask

  ////////////////////////////////////////////////////////////
  // Random traffic on the upstream fields and the rx lanes

  always @(posedge clk_wr) begin : traffic_gen
    logic [31:0]       r [6];
    logic [lane_w-1:0] lane0;
    for (int i = 0; i < 6; i++) begin
      traffic_rand = lcg_next(traffic_rand);
      r[i] = traffic_rand;
    end
    ustrm_data      <= {r[0], r[1]};
    ustrm_state     <= r[2][31:28];
    ustrm_protid    <= r[2][27:26];
    ustrm_dvalid    <= r[2][25];
    ustrm_crc       <= r[2][24:23];
    ustrm_crc_valid <= r[2][22];
    ustrm_valid     <= r[2][21];
    lane0 = {r[4][31:24], r[3]};
    // Strobe set about three times in four
    lane0[lane_data0_w] = r[4][23] | r[4][22];
    rx_phy0 <= lane0;
    rx_phy1 <= {r[4][15:8], r[5]};
  end

  ////////////////////////////////////////////////////////////
  // Reference model and output checks

  task automatic check_outputs();
    logic [lpif_word_w-1:0] dstrm_word;
    logic [31:0]            exp_status;
    dstrm_word = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                  dstrm_crc, dstrm_crc_valid, dstrm_valid};
    // Bit 19 tx level, bit 18 rx level
    exp_status = {12'h000, m_tx_dly, m_rx_dly, 18'h00000};
    checks += 5;
    assert (tx_phy0 === m_phy0)
      else report_mismatch("tx_phy0", 128'(m_phy0), 128'(tx_phy0));
    assert (tx_phy1 === m_phy1)
      else report_mismatch("tx_phy1", 128'(m_phy1), 128'(tx_phy1));
    assert (dstrm_word === m_dstrm)
      else report_mismatch("dstrm word", 128'(m_dstrm), 128'(dstrm_word));
    assert (rx_downstream_debug_status === exp_status)
      else report_mismatch("rx debug", 128'(exp_status), 128'(rx_downstream_debug_status));
    assert (tx_upstream_debug_status === exp_status)
      else report_mismatch("tx debug", 128'(exp_status), 128'(tx_upstream_debug_status));
  endtask

  task automatic model_step();
    logic [lpif_word_w-1:0] up_word;
    logic [lane_w-1:0]      lane0;
    logic [lane_w-1:0]      lane1;
    int                     n_tx_cnt;
    int                     n_rx_cnt;
    logic                   n_tx_dly;
    logic                   n_rx_dly;
    // MSB first, state on top
    up_word = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
               ustrm_crc, ustrm_crc_valid, ustrm_valid};
    lane0 = '0;
    lane1 = '0;
    lane0[lane_data0_w-1:0] = up_word[lane_data0_w-1:0];
    lane0[lane_data0_w]     = 1'b1;
    lane1[lane_data1_w-1:0] = up_word[lpif_word_w-1:lane_data0_w];
    n_tx_cnt = 0;
    n_rx_cnt = 0;
    n_tx_dly = 1'b0;
    n_rx_dly = 1'b0;
    // Edges with tx_online high, first one counts as 1
    if (tx_online) begin
      n_tx_cnt = m_tx_cnt + 1;
      n_tx_dly = m_tx_dly || (n_tx_cnt - 1 == int'(m_dx) + 1);
    end
    // Rx enable needs both rx_online and the delayed tx level
    if (tx_online && rx_online && m_tx_dly) begin
      n_rx_cnt = m_rx_cnt + 1;
      n_rx_dly = m_rx_dly || (n_rx_cnt - 1 == int'(m_dy) + int'(m_dz) + 2);
    end
    if (!rst_n) begin
      m_dx     = '0;
      m_dy     = '0;
      m_dz     = '0;
      m_tx_cnt = 0;
      m_rx_cnt = 0;
      m_tx_dly = 1'b0;
      m_rx_dly = 1'b0;
      m_phy0   = '0;
      m_phy1   = '0;
      m_dstrm  = '0;
    end else begin
      m_dstrm = (m_rx_stb && m_rx_dly) ? m_rx_word : '0;
      m_phy0  = m_tx_dly ? lane0 : '0;
      m_phy1  = m_tx_dly ? lane1 : '0;
      if (!tx_online) begin
        m_dx = delay_x_value;
        m_dy = delay_y_value;
        m_dz = delay_z_value;
      end
      m_tx_cnt = n_tx_cnt;
      m_rx_cnt = n_rx_cnt;
      m_tx_dly = n_tx_dly;
      m_rx_dly = n_rx_dly;
    end
    // Lane register has no reset
    m_rx_word = {rx_phy1[lane_data1_w-1:0], rx_phy0[lane_data0_w-1:0]};
    m_rx_stb  = rx_phy0[lane_data0_w];
  endtask

  always @(negedge clk_wr) begin
    check_outputs();
    model_step();
  end

  // Edges from the next rising edge until a debug bit is seen high
  task automatic wait_status_rise(input logic [4:0] bit_idx, output int cycles);
    int n;
    n = 0;
    do begin
      @(posedge clk_wr);
      n++;
      @(negedge clk_wr);
    end while (!rx_downstream_debug_status[bit_idx] && n < rise_limit);
    assert (rx_downstream_debug_status[bit_idx])
      else begin
        errors++;
        $display("%s: debug status bit %0d did not rise within %0d cycles",
                 test_name, bit_idx, rise_limit);
      end
    cycles = n - 1;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin : main_flow
    int dx;
    int dy;
    int dz;
    int cyc;
    main_rand       = lcg_seed;
    traffic_rand    = ~lcg_seed;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    delay_z_value   = '0;
    rx_phy0         = '0;
    rx_phy1         = '0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = '0;
    ustrm_crc       = '0;
    ustrm_crc_valid = '0;
    ustrm_valid     = '0;
    repeat (2) @(posedge clk_wr);
    rst_n <= 1'b1;

    // Everything quiet with both online inputs low
    test_name = "reset_state";
    repeat (3) begin
      @(negedge clk_wr);
      checks += 3;
      assert ({tx_phy1, tx_phy0} === '0)
        else report_mismatch("lanes", 128'(0), 128'({tx_phy1, tx_phy0}));
      assert ({dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid, dstrm_crc,
               dstrm_crc_valid, dstrm_valid} === '0)
        else report_mismatch("dstrm", 128'(0),
                             128'({dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                                   dstrm_crc, dstrm_crc_valid, dstrm_valid}));
      assert ({rx_downstream_debug_status, tx_upstream_debug_status} === '0)
        else report_mismatch("debug", 128'(0),
                             128'({rx_downstream_debug_status, tx_upstream_debug_status}));
    end

    for (int s = 0; s < num_sessions; s++) begin
      test_name = "online_delay";
      @(posedge clk_wr);
      main_rand = lcg_next(main_rand);
      dx = int'(main_rand[18:16]);
      dy = int'(main_rand[21:19]);
      dz = int'(main_rand[24:22]);
      delay_x_value <= delay_w'(dx);
      delay_y_value <= delay_w'(dy);
      delay_z_value <= delay_w'(dz);
      @(posedge clk_wr);
      tx_online <= 1'b1;
      rx_online <= 1'b1;
      wait_status_rise(5'd19, cyc);
      checks++;
      assert (cyc == dx + 1)
        else report_mismatch("tx rise cycles", 128'(dx + 1), 128'(cyc));
      wait_status_rise(5'd18, cyc);
      checks++;
      assert (cyc == dy + dz + 2)
        else report_mismatch("rx rise cycles", 128'(dy + dz + 2), 128'(cyc));

      // Large rewrite mid-session, rx bounce must still use the old counts
      test_name = "config_freeze";
      @(posedge clk_wr);
      main_rand = lcg_next(main_rand);
      delay_x_value <= delay_w'(main_rand[31:16]) | delay_w'(16'h0100);
      delay_y_value <= delay_w'(main_rand[15:0]) | delay_w'(16'h0100);
      delay_z_value <= delay_w'(main_rand[23:8]) | delay_w'(16'h0100);
      rx_online <= 1'b0;
      @(posedge clk_wr);
      rx_online <= 1'b1;
      wait_status_rise(5'd18, cyc);
      checks++;
      assert (cyc == dy + dz + 2)
        else report_mismatch("rx rise cycles", 128'(dy + dz + 2), 128'(cyc));

      // Lanes and dstrm follow the model while fully up
      test_name = "traffic";
      repeat (traffic_cycles) @(posedge clk_wr);

      test_name = "drop";
      tx_online <= 1'b0;
      @(negedge clk_wr);
      @(negedge clk_wr);
      checks++;
      assert (rx_downstream_debug_status[19:18] === 2'b00)
        else report_mismatch("online levels", 128'(0),
                             128'(rx_downstream_debug_status[19:18]));
      @(negedge clk_wr);
      checks++;
      assert ({tx_phy1, tx_phy0} === '0)
        else report_mismatch("lanes", 128'(0), 128'({tx_phy1, tx_phy0}));
      @(posedge clk_wr);
      rx_online <= 1'b0;
    end

    test_name = "idle";
    repeat (4) @(posedge clk_wr);
    @(negedge clk_wr);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Hard stop in case a wait never returns
  initial begin : watchdog
    #((total_cycles + watchdog_margin) * clk_period);
    $display("watchdog expired in %s, the run did not finish in time", test_name);
    $display("checks %0d errors %0d", checks, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/lpif_link_pkg.sv
rtl/lpif_word_if.sv
rtl/link_sync_cfg.sv
rtl/link_auto_sync.sv
rtl/lpif_word_map.sv
rtl/phy_lane_concat.sv
rtl/lpif_link_slave_top.sv
testbench/tb_lpif_link_slave.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LPIF link slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_lpif_link_slave -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
